/* source/fu_pkg.sv */
`default_nettype none

package fu_pkg;

  // datapath width
  localparam int word_w = 64;
  typedef logic [word_w-1:0] word_t;

  // 32-entry reorder buffer
  localparam int rob_w = 5;
  typedef logic [rob_w-1:0] rob_idx_t;

  // 64 physical registers
  localparam int tag_w = 6;
  typedef logic [tag_w-1:0] tag_t;

  // multiplier depth and the multiplier bits retired per stage
  localparam int mult_stages  = 4;
  localparam int mult_slice_w = word_w / mult_stages;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_t;

  // an entry is younger than the branch when its distance from the
  // rollback point, walking toward the tail, does not pass the tail
  function automatic logic is_squashed(
    rob_idx_t entry_idx,
    logic     rollback_en,
    rob_idx_t rollback_idx,
    rob_idx_t rob_tail
  );
    rob_idx_t entry_age;
    rob_idx_t tail_age;
    entry_age = entry_idx - rollback_idx;
    tail_age  = rob_tail - rollback_idx;
    return rollback_en && (entry_age <= tail_age);
  endfunction

endpackage

`default_nettype wire

/* source/fu_issue_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one operation handed from the issue stage to a functional unit
interface fu_issue_if;

  logic              valid;
  fu_pkg::alu_func_t func;
  fu_pkg::word_t     op_a;
  fu_pkg::word_t     op_b;
  fu_pkg::rob_idx_t  rob_idx;
  fu_pkg::tag_t      tag;

  modport unit (
    input valid,
    input func,
    input op_a,
    input op_b,
    input rob_idx,
    input tag
  );

  modport source (
    output valid,
    output func,
    output op_a,
    output op_b,
    output rob_idx,
    output tag
  );

endinterface

`default_nettype wire

/* source/fu_result_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one unit's result toward the result bus, grant comes back
interface fu_result_if;

  logic             done;
  fu_pkg::word_t    result;
  fu_pkg::rob_idx_t rob_idx;
  fu_pkg::tag_t     tag;
  logic             grant;

  modport unit (
    output done,
    output result,
    output rob_idx,
    output tag,
    input  grant
  );

  modport sink (
    input  done,
    input  result,
    input  rob_idx,
    input  tag,
    output grant
  );

endinterface

`default_nettype wire

/* source/alu_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
  fu_issue_if.unit         issue,
  fu_result_if.unit        result,
  output logic             ready,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail
);

  localparam int shamt_w = $clog2(fu_pkg::word_w);

  fu_pkg::word_t        op_a;
  fu_pkg::word_t        op_b;
  fu_pkg::word_t        sign_fill;
  logic [shamt_w-1:0]   shamt;

  // signed less-than from the sign bits and an unsigned compare
  function automatic logic signed_lt(fu_pkg::word_t a, fu_pkg::word_t b);
    if (a[fu_pkg::word_w-1] == b[fu_pkg::word_w-1]) begin
      return a < b;
    end
    return a[fu_pkg::word_w-1];
  endfunction

  assign op_a  = issue.op_a;
  assign op_b  = issue.op_b;
  assign shamt = op_b[shamt_w-1:0];

  // ones in the bit positions vacated by a right shift of shamt
  assign sign_fill = {fu_pkg::word_w{op_a[fu_pkg::word_w-1]}}
                   & ~({fu_pkg::word_w{1'b1}} >> shamt);

  always_comb begin
    case (issue.func)
      fu_pkg::alu_add:    result.result = op_a + op_b;
      fu_pkg::alu_sub:    result.result = op_a - op_b;
      fu_pkg::alu_and:    result.result = op_a & op_b;
      fu_pkg::alu_bic:    result.result = op_a & ~op_b;
      fu_pkg::alu_bis:    result.result = op_a | op_b;
      fu_pkg::alu_ornot:  result.result = op_a | ~op_b;
      fu_pkg::alu_xor:    result.result = op_a ^ op_b;
      fu_pkg::alu_eqv:    result.result = op_a ^ ~op_b;
      fu_pkg::alu_srl:    result.result = op_a >> shamt;
      fu_pkg::alu_sll:    result.result = op_a << shamt;
      fu_pkg::alu_sra:    result.result = (op_a >> shamt) | sign_fill;
      fu_pkg::alu_cmpult: result.result = fu_pkg::word_t'(op_a < op_b);
      fu_pkg::alu_cmpeq:  result.result = fu_pkg::word_t'(op_a == op_b);
      fu_pkg::alu_cmpule: result.result = fu_pkg::word_t'(op_a <= op_b);
      fu_pkg::alu_cmplt:  result.result = fu_pkg::word_t'(signed_lt(op_a, op_b));
      fu_pkg::alu_cmple:  result.result = fu_pkg::word_t'(signed_lt(op_a, op_b) || op_a == op_b);
      default:            result.result = 'x;
    endcase
  end

  // tags ride along untouched
  assign result.rob_idx = issue.rob_idx;
  assign result.tag     = issue.tag;
  assign result.done    = issue.valid
                       && !fu_pkg::is_squashed(issue.rob_idx, rollback_en, rollback_idx, rob_tail);

  // issuer holds its operation until the bus takes the result
  assign ready = result.grant;

  // issue stage must never present a valid op with an unknown function
  always_comb begin
    if (issue.valid) begin
      assert final (!$isunknown(issue.func))
        else $error("alu issued with unknown func");
    end
  end

endmodule

`default_nettype wire

/* source/mult_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_stage (
  input  logic             clock,
  input  logic             reset,
  input  logic             advance,
  input  logic             squash_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail,
  input  logic             live_in,
  input  fu_pkg::word_t    product_in,
  input  fu_pkg::word_t    mplier_in,
  input  fu_pkg::word_t    mcand_in,
  input  fu_pkg::rob_idx_t rob_idx_in,
  input  fu_pkg::tag_t     tag_in,
  output logic             live_out,
  output fu_pkg::word_t    product_out,
  output fu_pkg::word_t    mplier_out,
  output fu_pkg::word_t    mcand_out,
  output fu_pkg::rob_idx_t rob_idx_out,
  output fu_pkg::tag_t     tag_out
);

  logic          live_q;
  logic          own_squash;
  fu_pkg::word_t partial;

  // low slice of the multiplier against the already shifted multiplicand
  assign partial = fu_pkg::word_t'(mplier_in[fu_pkg::mult_slice_w-1:0]) * mcand_in;

  assign own_squash = fu_pkg::is_squashed(rob_idx_out, squash_en, rollback_idx, rob_tail);

  // a squashed entry stops looking live in the rollback cycle itself
  assign live_out = live_q && !own_squash;

  always_ff @(posedge clock) begin
    if (reset) begin
      live_q <= 1'b0;
    end else if (advance) begin
      live_q <= live_in;
    end else begin
      live_q <= live_out;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= product_in + partial;
      mplier_out  <= mplier_in >> fu_pkg::mult_slice_w;
      mcand_out   <= mcand_in << fu_pkg::mult_slice_w;
      rob_idx_out <= rob_idx_in;
      tag_out     <= tag_in;
    end
  end

  // a live entry that is neither moved nor squashed keeps everything
  assert property (@(posedge clock) disable iff (reset)
    live_q && !advance && !own_squash |=>
      live_q && $stable({product_out, mplier_out, mcand_out, rob_idx_out, tag_out}))
    else $error("mult stage contents changed while stalled");

endmodule

`default_nettype wire

/* source/mult_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module mult_pipeline (
  input  logic             clock,
  input  logic             reset,
  fu_issue_if.unit         issue,
  fu_result_if.unit        result,
  output logic             ready,
  input  logic             rollback_en,
  input  fu_pkg::rob_idx_t rollback_idx,
  input  fu_pkg::rob_idx_t rob_tail
);

  localparam int n = fu_pkg::mult_stages;

  // entry 0 is the issue side, entry i+1 is the output of stage i
  logic             live    [n+1];
  fu_pkg::word_t    product [n+1];
  fu_pkg::word_t    mplier  [n+1];
  fu_pkg::word_t    mcand   [n+1];
  fu_pkg::rob_idx_t rob_idx [n+1];
  fu_pkg::tag_t     tag     [n+1];
  logic             advance;

  // the whole chain moves together or not at all
  assign advance = result.grant || !live[n];
  assign ready   = advance;

  // an op younger than the branch never enters
  assign live[0]    = issue.valid
                   && !fu_pkg::is_squashed(issue.rob_idx, rollback_en, rollback_idx, rob_tail);
  assign product[0] = '0;
  assign mplier[0]  = issue.op_a;
  assign mcand[0]   = issue.op_b;
  assign rob_idx[0] = issue.rob_idx;
  assign tag[0]     = issue.tag;

  for (genvar i = 0; i < n; i++) begin : g_stage
    mult_stage stage_i (
      .clock        (clock),
      .reset        (reset),
      .advance      (advance),
      .squash_en    (rollback_en),
      .rollback_idx (rollback_idx),
      .rob_tail     (rob_tail),
      .live_in      (live[i]),
      .product_in   (product[i]),
      .mplier_in    (mplier[i]),
      .mcand_in     (mcand[i]),
      .rob_idx_in   (rob_idx[i]),
      .tag_in       (tag[i]),
      .live_out     (live[i+1]),
      .product_out  (product[i+1]),
      .mplier_out   (mplier[i+1]),
      .mcand_out    (mcand[i+1]),
      .rob_idx_out  (rob_idx[i+1]),
      .tag_out      (tag[i+1])
    );
  end

  // last stage live flag already carries its own squash check
  assign result.done    = live[n];
  assign result.result  = product[n];
  assign result.rob_idx = rob_idx[n];
  assign result.tag     = tag[n];

  assert property (@(posedge clock) reset |=> !result.done)
    else $error("mult done high right after reset");

  // bus sees a steady result while it withholds the grant
  assert property (@(posedge clock) disable iff (reset)
    result.done && !result.grant |=> $stable({result.result, result.rob_idx, result.tag}))
    else $error("mult result changed while waiting for grant");

endmodule

`default_nettype wire

/* source/fu_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_bank (
  input  logic              clock,
  input  logic              reset,
  input  logic              alu_valid,
  input  fu_pkg::alu_func_t alu_func,
  input  fu_pkg::word_t     alu_op_a,
  input  fu_pkg::word_t     alu_op_b,
  input  fu_pkg::rob_idx_t  alu_rob_idx,
  input  fu_pkg::tag_t      alu_tag,
  input  logic              mult_valid,
  input  fu_pkg::word_t     mult_op_a,
  input  fu_pkg::word_t     mult_op_b,
  input  fu_pkg::rob_idx_t  mult_rob_idx,
  input  fu_pkg::tag_t      mult_tag,
  input  logic              alu_grant,
  input  logic              mult_grant,
  input  logic              rollback_en,
  input  fu_pkg::rob_idx_t  rollback_idx,
  input  fu_pkg::rob_idx_t  rob_tail,
  output logic              alu_ready,
  output logic              alu_done,
  output fu_pkg::word_t     alu_result,
  output fu_pkg::rob_idx_t  alu_res_rob_idx,
  output fu_pkg::tag_t      alu_res_tag,
  output logic              mult_ready,
  output logic              mult_done,
  output fu_pkg::word_t     mult_result,
  output fu_pkg::rob_idx_t  mult_res_rob_idx,
  output fu_pkg::tag_t      mult_res_tag
);

  fu_issue_if  alu_issue ();
  fu_issue_if  mult_issue ();
  fu_result_if alu_res ();
  fu_result_if mult_res ();

  assign alu_issue.valid   = alu_valid;
  assign alu_issue.func    = alu_func;
  assign alu_issue.op_a    = alu_op_a;
  assign alu_issue.op_b    = alu_op_b;
  assign alu_issue.rob_idx = alu_rob_idx;
  assign alu_issue.tag     = alu_tag;

  // multiplier has no function select
  assign mult_issue.valid   = mult_valid;
  assign mult_issue.func    = fu_pkg::alu_add;
  assign mult_issue.op_a    = mult_op_a;
  assign mult_issue.op_b    = mult_op_b;
  assign mult_issue.rob_idx = mult_rob_idx;
  assign mult_issue.tag     = mult_tag;

  assign alu_res.grant    = alu_grant;
  assign alu_done         = alu_res.done;
  assign alu_result       = alu_res.result;
  assign alu_res_rob_idx  = alu_res.rob_idx;
  assign alu_res_tag      = alu_res.tag;

  assign mult_res.grant   = mult_grant;
  assign mult_done        = mult_res.done;
  assign mult_result      = mult_res.result;
  assign mult_res_rob_idx = mult_res.rob_idx;
  assign mult_res_tag     = mult_res.tag;

  alu_unit alu_i (
    .issue        (alu_issue),
    .result       (alu_res),
    .ready        (alu_ready),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail     (rob_tail)
  );

  mult_pipeline mult_i (
    .clock        (clock),
    .reset        (reset),
    .issue        (mult_issue),
    .result       (mult_res),
    .ready        (mult_ready),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .rob_tail     (rob_tail)
  );

endmodule

`default_nettype wire

/* tests/fu_bank_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_bank_tb;

  typedef struct {
    int                beh;
    logic              is_mult;
    logic              valid;
    fu_pkg::alu_func_t func;
    fu_pkg::word_t     a;
    fu_pkg::word_t     b;
    fu_pkg::rob_idx_t  idx;
    fu_pkg::tag_t      tag;
    logic              mgrant;
    logic              rb_en;
    fu_pkg::rob_idx_t  rb_idx;
    fu_pkg::rob_idx_t  rb_tail;
  } row_t;

  // one product still owed by the multiplier
  typedef struct {
    fu_pkg::word_t    prod;
    fu_pkg::rob_idx_t idx;
    fu_pkg::tag_t     tag;
    int               stage;
  } pending_t;

  logic              clock;
  logic              reset;
  logic              alu_valid;
  fu_pkg::alu_func_t alu_func;
  fu_pkg::word_t     alu_op_a;
  fu_pkg::word_t     alu_op_b;
  fu_pkg::rob_idx_t  alu_rob_idx;
  fu_pkg::tag_t      alu_tag;
  logic              mult_valid;
  fu_pkg::word_t     mult_op_a;
  fu_pkg::word_t     mult_op_b;
  fu_pkg::rob_idx_t  mult_rob_idx;
  fu_pkg::tag_t      mult_tag;
  logic              alu_grant;
  logic              mult_grant;
  logic              rollback_en;
  fu_pkg::rob_idx_t  rollback_idx;
  fu_pkg::rob_idx_t  rob_tail;
  logic              alu_ready;
  logic              alu_done;
  fu_pkg::word_t     alu_result;
  fu_pkg::rob_idx_t  alu_res_rob_idx;
  fu_pkg::tag_t      alu_res_tag;
  logic              mult_ready;
  logic              mult_done;
  fu_pkg::word_t     mult_result;
  fu_pkg::rob_idx_t  mult_res_rob_idx;
  fu_pkg::tag_t      mult_res_tag;

  row_t        rows[$];
  pending_t    owed[$];
  logic [31:0] rng_state = 32'h67b3513c;
  int          checks;
  int          errors;
  int          err_mark;
  int          cycle_count;
  int          timeout_limit;
  string       beh_name [1:5] = '{"alu operations", "single multiply",
                                  "back-to-back multiplies", "multiplier stall",
                                  "rollback squash"};

  fu_bank fu_bank_i (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic rand_word(output fu_pkg::word_t w);
    rng_state = xorshift32(rng_state);
    w[63:32] = rng_state;
    rng_state = xorshift32(rng_state);
    w[31:0] = rng_state;
  endtask

  // age rule, distances measured forward from the rollback point
  function automatic logic age_squashed(int idx, logic en, int rb_idx, int tail);
    int entry_dist;
    int tail_dist;
    entry_dist = (idx - rb_idx + 32) % 32;
    tail_dist  = (tail - rb_idx + 32) % 32;
    return en && (entry_dist <= tail_dist);
  endfunction

  function automatic fu_pkg::word_t expected_alu(fu_pkg::alu_func_t f, fu_pkg::word_t a,
                                                 fu_pkg::word_t b);
    logic [5:0] sh;
    sh = b[5:0];
    case (f)
      fu_pkg::alu_add:    return a + b;
      fu_pkg::alu_sub:    return a - b;
      fu_pkg::alu_and:    return a & b;
      fu_pkg::alu_bic:    return a & ~b;
      fu_pkg::alu_bis:    return a | b;
      fu_pkg::alu_ornot:  return a | ~b;
      fu_pkg::alu_xor:    return a ^ b;
      fu_pkg::alu_eqv:    return ~(a ^ b);
      fu_pkg::alu_srl:    return a >> sh;
      fu_pkg::alu_sll:    return a << sh;
      fu_pkg::alu_sra:    return $signed(a) >>> sh;
      fu_pkg::alu_cmpult: return {63'd0, a < b};
      fu_pkg::alu_cmpeq:  return {63'd0, a == b};
      fu_pkg::alu_cmpule: return {63'd0, a <= b};
      fu_pkg::alu_cmplt:  return {63'd0, $signed(a) < $signed(b)};
      default:            return {63'd0, $signed(a) <= $signed(b)};
    endcase
  endfunction

  task automatic compare_value(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(int beh, logic is_mult, logic valid, fu_pkg::alu_func_t f,
                         fu_pkg::word_t a, fu_pkg::word_t b, int idx, int tag,
                         logic mgrant, logic rb_en, int rb_idx, int rb_tail);
    row_t r;
    r = '{beh, is_mult, valid, f, a, b, idx[4:0], tag[5:0], mgrant, rb_en,
          rb_idx[4:0], rb_tail[4:0]};
    rows.push_back(r);
  endtask

  task automatic alu_row(fu_pkg::alu_func_t f, fu_pkg::word_t a, fu_pkg::word_t b);
    add_row(1, 1'b0, 1'b1, f, a, b, rows.size() % 32, rows.size() % 64, 1'b1, 1'b0, 0, 0);
  endtask

  task automatic mult_row(int beh, int idx, int tag, logic mgrant);
    fu_pkg::word_t a;
    fu_pkg::word_t b;
    rand_word(a);
    rand_word(b);
    add_row(beh, 1'b1, 1'b1, fu_pkg::alu_add, a, b, idx, tag, mgrant, 1'b0, 0, 0);
  endtask

  task automatic idle_rows(int beh, int count, logic mgrant);
    repeat (count) add_row(beh, 1'b0, 1'b0, fu_pkg::alu_add, '0, '0, 0, 0, mgrant, 1'b0, 0, 0);
  endtask

  task automatic drive_row(row_t r);
    alu_valid    = r.valid && !r.is_mult;
    alu_func     = r.func;
    alu_op_a     = r.a;
    alu_op_b     = r.b;
    alu_rob_idx  = r.idx;
    alu_tag      = r.tag;
    mult_valid   = r.valid && r.is_mult;
    mult_op_a    = r.a;
    mult_op_b    = r.b;
    mult_rob_idx = r.idx;
    mult_tag     = r.tag;
    // one grant pattern serves both result buses
    alu_grant    = r.mgrant;
    mult_grant   = r.mgrant;
    rollback_en  = r.rb_en;
    rollback_idx = r.rb_idx;
    rob_tail     = r.rb_tail;
  endtask

  task automatic check_alu(row_t r);
    logic exp_done;
    exp_done = r.valid && !r.is_mult && !age_squashed(r.idx, r.rb_en, r.rb_idx, r.rb_tail);
    compare_value("alu ready", alu_ready, r.mgrant);
    compare_value("alu done", alu_done, exp_done);
    if (exp_done) begin
      compare_value("alu result", alu_result, expected_alu(r.func, r.a, r.b));
      compare_value("alu rob index", alu_res_rob_idx, r.idx);
      compare_value("alu tag", alu_res_tag, r.tag);
    end
  endtask

  task automatic check_mult(row_t r, int row);
    pending_t p;
    logic     exp_done;
    logic     exp_ready;
    // squashed products are no longer owed
    if (r.rb_en) begin
      for (int k = owed.size() - 1; k >= 0; k--) begin
        if (age_squashed(owed[k].idx, 1'b1, r.rb_idx, r.rb_tail)) owed.delete(k);
      end
    end
    // only the oldest owed product can sit in the last stage
    exp_done  = owed.size() > 0 && owed[0].stage == fu_pkg::mult_stages;
    exp_ready = r.mgrant || !exp_done;
    compare_value("mult done", mult_done, exp_done);
    compare_value("mult ready", mult_ready, exp_ready);
    if (exp_done) begin
      compare_value("mult product", mult_result, owed[0].prod);
      compare_value("mult rob index", mult_res_rob_idx, owed[0].idx);
      compare_value("mult tag", mult_res_tag, owed[0].tag);
      if (r.mgrant) p = owed.pop_front();
    end
    // the whole chain moves one stage at the coming edge
    if (exp_ready) begin
      foreach (owed[k]) owed[k].stage++;
    end
    if (r.valid && r.is_mult) begin
      if (!exp_ready) begin
        $display("error at %0t: row %0d offered a multiply while the pipeline was stalled",
                 $time, row);
        errors++;
      end else if (!age_squashed(r.idx, r.rb_en, r.rb_idx, r.rb_tail)) begin
        p = '{r.a * r.b, r.idx, r.tag, 1};
        owed.push_back(p);
      end
    end
  endtask

  task automatic report_behavior(int beh);
    $display("behavior %0d, %s: %0d errors", beh, beh_name[beh], errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    fu_pkg::word_t a;
    fu_pkg::word_t b;
    reset = 1'b1;
    drive_row('{0, 1'b0, 1'b0, fu_pkg::alu_add, '0, '0, '0, '0, 1'b0, 1'b0, '0, '0});
    cycle_count = 0;

    // corner operands around shifts and the sign boundary
    alu_row(fu_pkg::alu_sra, 64'h8000_0000_0000_0001, 64'd63);
    alu_row(fu_pkg::alu_sra, 64'h8000_0000_0000_0001, 64'd0);
    alu_row(fu_pkg::alu_srl, '1, 64'd63);
    alu_row(fu_pkg::alu_sll, 64'd1, 64'd63);
    alu_row(fu_pkg::alu_cmplt, '1, 64'd1);
    alu_row(fu_pkg::alu_cmpult, '1, 64'd1);
    alu_row(fu_pkg::alu_cmple, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
    alu_row(fu_pkg::alu_cmpule, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
    alu_row(fu_pkg::alu_add, '1, 64'd1);
    alu_row(fu_pkg::alu_sub, '0, 64'd1);
    rand_word(a);
    alu_row(fu_pkg::alu_cmpeq, a, a);
    for (int k = 0; k < 3; k++) begin
      rand_word(a);
      alu_row(fu_pkg::alu_func_t'(8 + k), a, 64'd0);
      alu_row(fu_pkg::alu_func_t'(8 + k), a, 64'd63);
    end
    repeat (2) begin
      for (int f = 0; f < 16; f++) begin
        rand_word(a);
        rand_word(b);
        alu_row(fu_pkg::alu_func_t'(f), a, b);
      end
    end

    mult_row(2, 9, 33, 1'b1);
    idle_rows(2, 5, 1'b1);

    for (int k = 0; k < 4; k++) mult_row(3, 10 + k, 1 + k, 1'b1);
    idle_rows(3, 6, 1'b1);

    // fill all four stages with the bus withholding its grant
    for (int k = 0; k < 4; k++) mult_row(4, 14 + k, 8 + k, 1'b0);
    idle_rows(4, 4, 1'b0);
    idle_rows(4, 6, 1'b1);

    // rollback to index 4 while indices 2..5 are spread over the stages
    for (int k = 0; k < 4; k++) mult_row(5, 2 + k, 40 + k, 1'b1);
    rand_word(a);
    rand_word(b);
    add_row(5, 1'b1, 1'b1, fu_pkg::alu_add, a, b, 7, 44, 1'b1, 1'b1, 4, 10);
    add_row(5, 1'b0, 1'b1, fu_pkg::alu_xor, a, b, 6, 45, 1'b1, 1'b1, 4, 10);
    add_row(5, 1'b0, 1'b1, fu_pkg::alu_sub, a, b, 1, 46, 1'b1, 1'b1, 4, 10);
    idle_rows(5, 4, 1'b1);
    // squash hits the product sitting in the last stage
    mult_row(5, 20, 50, 1'b1);
    mult_row(5, 21, 51, 1'b1);
    idle_rows(5, 2, 1'b1);
    add_row(5, 1'b0, 1'b0, fu_pkg::alu_add, '0, '0, 0, 0, 1'b1, 1'b1, 20, 25);
    idle_rows(5, 3, 1'b1);
    // window wrapping past index 31
    add_row(5, 1'b0, 1'b1, fu_pkg::alu_and, a, b, 0, 47, 1'b1, 1'b1, 30, 2);
    add_row(5, 1'b0, 1'b1, fu_pkg::alu_bis, a, b, 28, 48, 1'b1, 1'b1, 30, 2);
    idle_rows(5, 2, 1'b1);

    timeout_limit = rows.size() * 8 + 200;

    repeat (16) @(posedge clock);
    #1 reset = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clock);
      #1 drive_row(rows[i]);
      @(negedge clock);
      check_alu(rows[i]);
      check_mult(rows[i], i);
      if (i + 1 == rows.size() || rows[i + 1].beh != rows[i].beh) report_behavior(rows[i].beh);
    end

    if (owed.size() != 0) begin
      $display("error: %0d multiplier products never arrived", owed.size());
      errors++;
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fu_bank.f */
source/fu_pkg.sv
source/fu_issue_if.sv
source/fu_result_if.sv
source/alu_unit.sv
source/mult_stage.sv
source/mult_pipeline.sv
source/fu_bank.sv
tests/fu_bank_tb.sv
